//--- Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing
TOP       := tb_ac97
FILELIST  := sources.f

OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(wildcard *.sv *.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- ac97_buf_arbiter.sv
module ac97_buf_arbiter (
	input  logic			clk,
	input  logic			rst,
	input  ac97_pkg::ram_req_t	m_req,
	input  logic			m_valid,
	output logic			m_grant,
	output ac97_pkg::sample_t	m_rdata,
	input  ac97_pkg::ram_req_t	h_req,
	input  logic			h_valid,
	output logic			h_grant,
	output ac97_pkg::sample_t	h_rdata
);

	ac97_pkg::sample_t	mem [0:31];
	ac97_pkg::ram_req_t	sel;
	ac97_pkg::sample_t	rd_q;
	logic			any_grant;
	logic			m_served;
	logic			h_served;

	// Mover first, host takes what is left
	assign m_grant = m_valid;
	assign h_grant = h_valid & ~m_valid;
	assign any_grant = m_grant | h_grant;
	assign sel = m_valid ? m_req : h_req;

	always_ff @(posedge clk) begin
		if (any_grant && sel.we)
			mem[sel.addr] <= sel.data;
		if (any_grant && !sel.we)
			rd_q <= mem[sel.addr];
	end

	// Owner of the read register
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			m_served <= 1'b0;
			h_served <= 1'b0;
		end else begin
			m_served <= m_grant & ~m_req.we;
			h_served <= h_grant & ~h_req.we;
		end
	end

	assign m_rdata = m_served ? rd_q : '0;
	assign h_rdata = h_served ? rd_q : '0;

endmodule

//--- ac97_config.svh
`ifndef AC97_CONFIG_SVH
`define AC97_CONFIG_SVH

// Frame timing
`define AC97_SYNC_LEN	8'd16		// Sync high time at frame start
`define AC97_RES_SIG	4'h4		// Resume sync length in ps_ce ticks

// Output slot latch enables, 20 bit clocks apart
`define AC97_LE_SLOT0	8'h11
`define AC97_LE_SLOT1	8'h25
`define AC97_LE_SLOT2	8'h39
`define AC97_LE_SLOT3	8'h4d
`define AC97_LE_SLOT4	8'h61
`define AC97_LE_SLOT6	8'h89

// Input valid thresholds, strobe rises once the whole word is in the shifter
`define AC97_IN_SLOT3	8'h61
`define AC97_IN_SLOT4	8'h75

// Sample RAM layout, two rings of left/right pairs
`define AC97_RING_DEPTH	8
`define AC97_PLAY_BASE	5'd0
`define AC97_CAP_BASE	5'd16

`endif

//--- ac97_frame_timing.sv
`include "ac97_config.svh"

module ac97_frame_timing (
	input  logic			clk,
	input  logic			rst,
	input  logic			ps_ce,
	input  logic			suspend_req,
	input  logic			resume_req,
	output ac97_pkg::frame_evt_t	evt,
	output logic			suspended
);

	logic [7:0]		cnt;
	ac97_pkg::frame_evt_t	ev_q;
	logic			sync_resume;
	logic [3:0]		res_cnt;
	logic			resume_done;

	assign resume_done = sync_resume & (res_cnt == `AC97_RES_SIG);

	always_comb begin
		evt = ev_q;
		evt.sync = ev_q.sync | sync_resume;
	end

	// Bit clock counter, parked at 0xFF while suspended
	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			cnt <= 8'hff;
		else if (suspended)
			cnt <= 8'hff;
		else
			cnt <= cnt + 8'h1;
	end

	// Registered compares, one clock behind the counter
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ev_q <= '0;
			ev_q.valid <= 1'b1;		// Same as a compare on 0xFF
			ev_q.in_valid <= 3'b111;	// No false input edge after reset
		end else begin
			ev_q.ld <= (cnt == 8'h00);
			ev_q.sync <= (cnt < `AC97_SYNC_LEN);
			ev_q.valid <= (cnt > `AC97_LE_SLOT2);
			ev_q.out_le[0] <= (cnt == `AC97_LE_SLOT0);
			ev_q.out_le[1] <= (cnt == `AC97_LE_SLOT1);
			ev_q.out_le[2] <= (cnt == `AC97_LE_SLOT2);
			ev_q.out_le[3] <= (cnt == `AC97_LE_SLOT3);
			ev_q.out_le[4] <= (cnt == `AC97_LE_SLOT4);
			ev_q.out_le[5] <= (cnt == `AC97_LE_SLOT6);
			ev_q.in_valid[0] <= (cnt > `AC97_IN_SLOT3);
			ev_q.in_valid[1] <= (cnt > `AC97_IN_SLOT4);
			ev_q.in_valid[2] <= (cnt > `AC97_LE_SLOT6);
		end
	end

	// Enter suspend only at the end of a frame, after all slots left the shifter
	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			suspended <= 1'b0;
		else if (resume_done)
			suspended <= 1'b0;
		else if (suspend_req && cnt == 8'hfe)
			suspended <= 1'b1;
	end

	// Resume signalling on sync
	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			sync_resume <= 1'b0;
		else if (resume_done)
			sync_resume <= 1'b0;
		else if (suspended && resume_req)
			sync_resume <= 1'b1;
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			res_cnt <= 4'h0;
		else if (!sync_resume)
			res_cnt <= 4'h0;
		else if (ps_ce)
			res_cnt <= res_cnt + 4'h1;
	end

endmodule

//--- ac97_in_shift.sv
module ac97_in_shift (
	input  logic			clk,
	input  logic			rst,
	input  ac97_pkg::frame_evt_t	evt,
	input  logic			sdata_in,
	output ac97_pkg::sample_t	cap_l,
	output ac97_pkg::sample_t	cap_r,
	output logic			cap_done
);

	ac97_pkg::sample_t	sr;
	logic [1:0]		iv_q;
	logic [1:0]		iv_rise;

	assign iv_rise = evt.in_valid[1:0] & ~iv_q;

	always_ff @(posedge clk)
		sr <= {sr[18:0], sdata_in};

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			iv_q <= 2'b11;		// Strobes come out of reset high
			cap_done <= 1'b0;
		end else begin
			iv_q <= evt.in_valid[1:0];
			cap_done <= iv_rise[1];	// Pair complete after slot 4
		end
	end

	// Slot 3 is left, slot 4 is right
	always_ff @(posedge clk) begin
		if (iv_rise[0])
			cap_l <= sr;
		if (iv_rise[1])
			cap_r <= sr;
	end

endmodule

//--- ac97_out_shift.sv
module ac97_out_shift (
	input  logic			clk,
	input  logic			rst,
	input  ac97_pkg::frame_evt_t	evt,
	input  ac97_pkg::sample_t	pcm_l,
	input  ac97_pkg::sample_t	pcm_r,
	input  logic			pcm_valid,
	output logic			sdata_out
);

	ac97_pkg::sample_t	sr;
	logic [15:0]		tag;

	// Frame valid, slots 1/2 empty, slots 3/4 valid
	assign tag = {pcm_valid, 2'b00, pcm_valid, pcm_valid, 11'h000};

	assign sdata_out = sr[19];	// MSB first

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			sr <= '0;
		else if (evt.out_le[0])
			sr <= {tag, 4'h0};		// Tag fills the top 16 bits
		else if (evt.out_le[3])
			sr <= pcm_l;
		else if (evt.out_le[4])
			sr <= pcm_r;
		else if (evt.out_le[1] | evt.out_le[2] | evt.out_le[5])
			sr <= '0;			// No register access, slot 6 unused
		else
			sr <= {sr[18:0], 1'b0};
	end

endmodule

//--- ac97_pkg.sv
package ac97_pkg;

	// One slot word
	typedef logic [19:0] sample_t;

	// Per-cycle frame strobes from the timing block
	typedef struct packed {
		logic		ld;		// Once per frame
		logic		sync;
		logic		valid;
		logic [5:0]	out_le;		// Slots 0,1,2,3,4,6
		logic [2:0]	in_valid;	// Slots 3,4,6
	} frame_evt_t;

	// Sample RAM access
	typedef struct packed {
		logic		we;
		logic [4:0]	addr;
		sample_t	data;
	} ram_req_t;

	// Wishbone classic, host side
	typedef struct packed {
		logic		cyc;
		logic		stb;
		logic		we;
		logic [7:0]	adr;
		logic [31:0]	dat;
	} wb_req_t;

	typedef struct packed {
		logic [31:0]	dat;
		logic		ack;
	} wb_rsp_t;

endpackage

//--- ac97_slot_mover.sv
`include "ac97_config.svh"

module ac97_slot_mover (
	input  logic			clk,
	input  logic			rst,
	input  ac97_pkg::frame_evt_t	evt,
	input  logic			cap_done,
	input  ac97_pkg::sample_t	cap_l,
	input  ac97_pkg::sample_t	cap_r,
	output ac97_pkg::ram_req_t	ram_req,
	output logic			ram_valid,
	input  logic			ram_grant,
	input  ac97_pkg::sample_t	ram_rdata,
	output ac97_pkg::sample_t	pcm_l,
	output ac97_pkg::sample_t	pcm_r,
	output logic			pcm_valid
);

	localparam int IW = $clog2(`AC97_RING_DEPTH);

	typedef enum logic [2:0] {
		MV_IDLE,
		MV_RD_L,
		MV_RD_R,
		MV_RD_DONE,
		MV_WR_L,
		MV_WR_R
	} mv_state_t;

	mv_state_t	state;
	logic [IW-1:0]	play_idx;
	logic [IW-1:0]	cap_idx;

	function automatic logic [IW-1:0] ring_next(input logic [IW-1:0] idx);
		if (idx == IW'(`AC97_RING_DEPTH - 1))
			return '0;
		return idx + 1'b1;
	endfunction

	// Request per state, words of a pair are adjacent
	always_comb begin
		ram_req = '0;
		ram_valid = 1'b0;
		case (state)
			MV_RD_L: begin
				ram_valid = 1'b1;
				ram_req.addr = `AC97_PLAY_BASE + 5'({play_idx, 1'b0});
			end
			MV_RD_R: begin
				ram_valid = 1'b1;
				ram_req.addr = `AC97_PLAY_BASE + 5'({play_idx, 1'b1});
			end
			MV_WR_L: begin
				ram_valid = 1'b1;
				ram_req.we = 1'b1;
				ram_req.addr = `AC97_CAP_BASE + 5'({cap_idx, 1'b0});
				ram_req.data = cap_l;
			end
			MV_WR_R: begin
				ram_valid = 1'b1;
				ram_req.we = 1'b1;
				ram_req.addr = `AC97_CAP_BASE + 5'({cap_idx, 1'b1});
				ram_req.data = cap_r;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= MV_IDLE;
			play_idx <= '0;
			cap_idx <= '0;
			pcm_valid <= 1'b0;
		end else begin
			case (state)
				MV_IDLE:
					if (evt.ld)
						state <= MV_RD_L;
					else if (cap_done)
						state <= MV_WR_L;
				MV_RD_L:
					if (ram_grant)
						state <= MV_RD_R;
				MV_RD_R:
					if (ram_grant)
						state <= MV_RD_DONE;
				MV_RD_DONE: begin
					state <= MV_IDLE;
					pcm_valid <= 1'b1;
					play_idx <= ring_next(play_idx);
				end
				MV_WR_L:
					if (ram_grant)
						state <= MV_WR_R;
				MV_WR_R:
					if (ram_grant) begin
						state <= MV_IDLE;
						cap_idx <= ring_next(cap_idx);
					end
				default:
					state <= MV_IDLE;
			endcase
		end
	end

	// Read data trails the grant by one cycle
	always_ff @(posedge clk) begin
		if (state == MV_RD_R)
			pcm_l <= ram_rdata;
		if (state == MV_RD_DONE)
			pcm_r <= ram_rdata;
	end

endmodule

//--- ac97_top.sv
module ac97_top (
	input  logic			clk,
	input  logic			rst,
	input  logic			ps_ce,
	input  logic			sdata_in,
	output logic			sync,
	output logic			sdata_out,
	output logic			suspended,
	input  ac97_pkg::wb_req_t	wb_i,
	output ac97_pkg::wb_rsp_t	wb_o
);

	ac97_pkg::frame_evt_t	evt;
	logic			suspend_req;
	logic			resume_req;
	ac97_pkg::sample_t	pcm_l;
	ac97_pkg::sample_t	pcm_r;
	logic			pcm_valid;
	ac97_pkg::sample_t	cap_l;
	ac97_pkg::sample_t	cap_r;
	logic			cap_done;
	ac97_pkg::ram_req_t	m_req;
	logic			m_valid;
	logic			m_grant;
	ac97_pkg::sample_t	m_rdata;
	ac97_pkg::ram_req_t	h_req;
	logic			h_valid;
	logic			h_grant;
	ac97_pkg::sample_t	h_rdata;

	assign sync = evt.sync;

	ac97_frame_timing u_timing (
		.clk		(clk),
		.rst		(rst),
		.ps_ce		(ps_ce),
		.suspend_req	(suspend_req),
		.resume_req	(resume_req),
		.evt		(evt),
		.suspended	(suspended)
	);

	ac97_out_shift u_out (
		.clk		(clk),
		.rst		(rst),
		.evt		(evt),
		.pcm_l		(pcm_l),
		.pcm_r		(pcm_r),
		.pcm_valid	(pcm_valid),
		.sdata_out	(sdata_out)
	);

	ac97_in_shift u_in (
		.clk		(clk),
		.rst		(rst),
		.evt		(evt),
		.sdata_in	(sdata_in),
		.cap_l		(cap_l),
		.cap_r		(cap_r),
		.cap_done	(cap_done)
	);

	ac97_slot_mover u_mover (
		.clk		(clk),
		.rst		(rst),
		.evt		(evt),
		.cap_done	(cap_done),
		.cap_l		(cap_l),
		.cap_r		(cap_r),
		.ram_req	(m_req),
		.ram_valid	(m_valid),
		.ram_grant	(m_grant),
		.ram_rdata	(m_rdata),
		.pcm_l		(pcm_l),
		.pcm_r		(pcm_r),
		.pcm_valid	(pcm_valid)
	);

	ac97_buf_arbiter u_arb (
		.clk		(clk),
		.rst		(rst),
		.m_req		(m_req),
		.m_valid	(m_valid),
		.m_grant	(m_grant),
		.m_rdata	(m_rdata),
		.h_req		(h_req),
		.h_valid	(h_valid),
		.h_grant	(h_grant),
		.h_rdata	(h_rdata)
	);

	ac97_wb_slave u_wb (
		.clk		(clk),
		.rst		(rst),
		.wb_i		(wb_i),
		.wb_o		(wb_o),
		.suspended	(suspended),
		.suspend_req	(suspend_req),
		.resume_req	(resume_req),
		.ram_req	(h_req),
		.ram_valid	(h_valid),
		.ram_grant	(h_grant),
		.ram_rdata	(h_rdata)
	);

endmodule

//--- ac97_wb_slave.sv
module ac97_wb_slave (
	input  logic			clk,
	input  logic			rst,
	input  ac97_pkg::wb_req_t	wb_i,
	output ac97_pkg::wb_rsp_t	wb_o,
	input  logic			suspended,
	output logic			suspend_req,
	output logic			resume_req,
	output ac97_pkg::ram_req_t	ram_req,
	output logic			ram_valid,
	input  logic			ram_grant,
	input  ac97_pkg::sample_t	ram_rdata
);

	logic		req;
	logic		is_ram;
	logic		ctrl_wr;
	logic		ack_q;
	logic		sel_ram_q;
	logic [31:0]	reg_dat_q;

	assign req = wb_i.cyc & wb_i.stb & ~ack_q;	// Quiet during the ack cycle
	assign is_ram = wb_i.adr[7];			// 0x80 and up
	assign ctrl_wr = req & wb_i.we & (wb_i.adr == 8'h00);

	assign ram_valid = req & is_ram;
	assign ram_req.we = wb_i.we;
	assign ram_req.addr = wb_i.adr[6:2];
	assign ram_req.data = wb_i.dat[19:0];

	assign wb_o.ack = ack_q;
	assign wb_o.dat = sel_ram_q ? {12'h000, ram_rdata} : reg_dat_q;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ack_q <= 1'b0;
			sel_ram_q <= 1'b0;
			suspend_req <= 1'b0;
			resume_req <= 1'b0;
		end else begin
			ack_q <= req & (~is_ram | ram_grant);	// RAM waits for the grant
			sel_ram_q <= req & is_ram;
			resume_req <= ctrl_wr & wb_i.dat[1];	// One cycle pulse
			if (ctrl_wr)
				suspend_req <= wb_i.dat[0];
		end
	end

	// Register read data
	always_ff @(posedge clk) begin
		case (wb_i.adr)
			8'h00:		reg_dat_q <= {31'h0, suspend_req};
			8'h04:		reg_dat_q <= {31'h0, suspended};
			default:	reg_dat_q <= 32'h0;
		endcase
	end

endmodule

//--- sources.f
+incdir+.
ac97_pkg.sv
ac97_frame_timing.sv
ac97_out_shift.sv
ac97_in_shift.sv
ac97_slot_mover.sv
ac97_buf_arbiter.sv
ac97_wb_slave.sv
ac97_top.sv
tb_ac97.sv

//--- tb_ac97.sv
`include "ac97_config.svh"

module tb_ac97;

	logic			clk;
	logic			rst;
	logic			ps_ce;
	logic			sdata_in;
	logic			sync;
	logic			sdata_out;
	logic			suspended;
	ac97_pkg::wb_req_t	wb_i;
	ac97_pkg::wb_rsp_t	wb_o;

	logic [1:0]		ps_div;
	ac97_pkg::sample_t	play_model [0:2*`AC97_RING_DEPTH-1];	// Host view of playback words
	int			checks = 0;
	int			errors = 0;
	int			checks_mark = 0;
	int			errors_mark = 0;

	assign sdata_in = sdata_out;	// Serial loopback

	ac97_top dut0 (
		.clk		(clk),
		.rst		(rst),
		.ps_ce		(ps_ce),
		.sdata_in	(sdata_in),
		.sync		(sync),
		.sdata_out	(sdata_out),
		.suspended	(suspended),
		.wb_i		(wb_i),
		.wb_o		(wb_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Prescaler tick every fourth bit clock
	initial begin
		ps_ce = 1'b0;
		ps_div = 2'd0;
		forever begin
			@(posedge clk);
			#1;
			ps_div = ps_div + 2'd1;
			ps_ce = (ps_div == 2'd3);
		end
	end

	task automatic abort_run(input string why);
		$display("Timeout: %s", why);
		$display("Testbench failed");
		$finish;
	endtask

	task automatic check_sample(input string name, input ac97_pkg::sample_t got,
			input ac97_pkg::sample_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] t=%0t %s: got %05h expected %05h", $time, name, got, exp);
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] t=%0t %s: got %08h expected %08h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] t=%0t %s: got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("[ERROR] t=%0t %s: got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic finish_test(input string name);
		$display("%s: %0d checks, %0d errors", name, checks - checks_mark,
			errors - errors_mark);
		checks_mark = checks;
		errors_mark = errors;
	endtask

	function automatic logic [7:0] ram_addr(input int word);
		return 8'h80 + 8'(word * 4);	// One RAM word per 4 bytes in the window
	endfunction

	// Wishbone classic write with the request held until ack
	task automatic bus_write(input logic [7:0] adr, input logic [31:0] dat);
		int n;
		@(posedge clk);
		#1;
		wb_i.cyc = 1'b1;
		wb_i.stb = 1'b1;
		wb_i.we = 1'b1;
		wb_i.adr = adr;
		wb_i.dat = dat;
		n = 0;
		while (wb_o.ack !== 1'b1) begin
			@(negedge clk);
			n++;
			if (n > 20)
				abort_run("Wishbone write was not acknowledged");
		end
		@(posedge clk);
		#1;
		wb_i = '0;
	endtask

	task automatic bus_read(input logic [7:0] adr, output logic [31:0] dat);
		int n;
		@(posedge clk);
		#1;
		wb_i.cyc = 1'b1;
		wb_i.stb = 1'b1;
		wb_i.we = 1'b0;
		wb_i.adr = adr;
		wb_i.dat = '0;
		n = 0;
		while (wb_o.ack !== 1'b1) begin
			@(negedge clk);
			n++;
			if (n > 20)
				abort_run("Wishbone read was not acknowledged");
		end
		dat = wb_o.dat;		// Data valid in the ack cycle
		@(posedge clk);
		#1;
		wb_i = '0;
	endtask

	task automatic wait_sync(input logic level, input int limit, output int cycles);
		cycles = 0;
		while (sync !== level) begin
			@(negedge clk);
			cycles++;
			if (cycles > limit)
				abort_run("sync did not reach the expected level in time");
		end
	endtask

	task automatic frame_spacing(input int frames);
		int high;
		int low;
		int skip;
		wait_sync(1'b0, 300, skip);
		wait_sync(1'b1, 300, skip);
		for (int f = 0; f < frames; f++) begin
			wait_sync(1'b0, 300, high);
			wait_sync(1'b1, 300, low);
			check_count("sync high cycles", high, int'(`AC97_SYNC_LEN));
			check_count("frame length", high + low, 256);
		end
	endtask

	// Playback pair k and capture pair k step together once per frame
	task automatic ring_loopback();
		logic [31:0]	d;
		int		skip;
		for (int k = 0; k < 2 * `AC97_RING_DEPTH; k++) begin
			play_model[k] = 20'($urandom);
			bus_write(ram_addr(`AC97_PLAY_BASE + k), {12'h000, play_model[k]});
		end
		repeat (`AC97_RING_DEPTH + 2) begin	// Every pair fetched and captured again
			wait_sync(1'b0, 300, skip);
			wait_sync(1'b1, 300, skip);
		end
		for (int k = 0; k < 2 * `AC97_RING_DEPTH; k++) begin
			bus_read(ram_addr(`AC97_CAP_BASE + k), d);
			check_sample($sformatf("capture[%0d]", k), d[19:0], play_model[k]);
		end
	endtask

	// Word starting at a bit offset from the sync rise
	function automatic ac97_pkg::sample_t slot_word(input logic [255:0] stream,
			input int offset);
		ac97_pkg::sample_t w;
		w = '0;
		for (int b = 0; b < 20; b++)
			w = {w[18:0], stream[offset + b]};
		return w;
	endfunction

	task automatic serial_slots(input int frames);
		logic [255:0]	stream;
		int		skip;
		for (int f = 0; f < frames; f++) begin
			wait_sync(1'b0, 300, skip);
			wait_sync(1'b1, 300, skip);
			stream[0] = sdata_out;
			for (int i = 1; i < 256; i++) begin
				@(negedge clk);
				stream[i] = sdata_out;
			end
			// Slot MSB shows two counts after its latch compare
			// Sync rises at count 1
			// Tag has frame valid plus slot 3 and 4 valid and codec ID 0
			check_sample("slot 0 tag", slot_word(stream, `AC97_LE_SLOT0 + 1), 20'h98000);
			check_sample("slot 1", slot_word(stream, `AC97_LE_SLOT1 + 1), 20'h00000);
			check_sample("slot 2", slot_word(stream, `AC97_LE_SLOT2 + 1), 20'h00000);
			check_sample("slot 6", slot_word(stream, `AC97_LE_SLOT6 + 1), 20'h00000);
		end
	endtask

	// Host traffic on the playback words while the mover fetches from them
	task automatic bus_contention(input int ops);
		int		w;
		logic [31:0]	d;
		for (int i = 0; i < ops; i++) begin
			w = int'($urandom_range(2 * `AC97_RING_DEPTH - 1, 0));
			if ($urandom_range(1, 0) == 1) begin
				d = $urandom;
				play_model[w] = d[19:0];	// Only 20 bits are stored
				bus_write(ram_addr(`AC97_PLAY_BASE + w), d);
			end else begin
				bus_read(ram_addr(`AC97_PLAY_BASE + w), d);
				check_word($sformatf("ram[%0d]", w), d, {12'h000, play_model[w]});
			end
			repeat ($urandom_range(3, 0)) @(posedge clk);
		end
	endtask

	task automatic suspend_resume();
		logic [31:0]	d;
		int		polls;
		int		sync_hi;
		int		data_hi;
		int		ticks;
		int		n;
		bus_write(8'h00, 32'h1);
		d = '0;
		polls = 0;
		while (d[0] !== 1'b1) begin		// Takes effect at the end of the frame
			bus_read(8'h04, d);
			polls++;
			if (polls > 300)
				abort_run("status never reported suspend");
		end
		check_word("status", d, 32'h1);
		check_bit("suspended", suspended, 1'b1);
		sync_hi = 0;
		data_hi = 0;
		repeat (512) begin
			@(negedge clk);
			if (sync)
				sync_hi++;
			if (sdata_out)
				data_hi++;
		end
		check_count("sync while suspended", sync_hi, 0);
		check_count("sdata_out while suspended", data_hi, 0);
		bus_write(8'h00, 32'h2);
		@(negedge clk);
		wait_sync(1'b1, 8, n);
		ticks = 0;
		n = 0;
		while (sync === 1'b1) begin
			if (ps_ce)
				ticks++;
			@(negedge clk);
			n++;
			if (n > 200)
				abort_run("resume sync did not end");
		end
		check_count("resume ps_ce ticks", ticks, int'(`AC97_RES_SIG));
		bus_read(8'h04, d);
		check_word("status", d, 32'h0);
		check_bit("suspended", suspended, 1'b0);
		frame_spacing(2);
	endtask

	initial begin
		void'($urandom(21298));
		rst = 1'b0;
		wb_i = '0;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b1;

		frame_spacing(3);
		finish_test("framing");
		ring_loopback();
		finish_test("loopback");
		serial_slots(2);
		finish_test("serial");
		bus_contention(300);
		finish_test("contention");
		suspend_resume();
		finish_test("suspend");

		$display("Total: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule
